//--- compile.f
src/pkt_pkg.sv
src/beat_fifo.sv
src/payload_incr.sv
src/tx_packet_buffer.sv
src/pkt_loopback_top.sv
verification/pkt_checker.sv
verification/tb_pkt_loopback.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the packet loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pkt_loopback \
  -f compile.f -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0

//--- src/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo import pkt_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  wr_en,
  input  beat_t wr_beat,
  output logic  full,
  output logic  afull,
  input  logic  rd_en,
  output logic  rd_valid,
  output beat_t rd_beat,
  output logic  empty
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  // Almost full once fewer than this many slots are free
  localparam int AFULL_MARGIN = 3;

  beat_t mem [FIFO_DEPTH];

  // Pointers carry one extra wrap bit
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] wr_ptr_nxt;
  logic [ADDR_W:0] rd_ptr;
  logic [ADDR_W:0] rd_ptr_nxt;
  logic [ADDR_W:0] level_nxt;
  logic            wr_ok;
  logic            rd_ok;

  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // ----------------------------------------------------------
  // Pointer update
  // ----------------------------------------------------------
  always_comb begin
    wr_ptr_nxt = wr_ptr;
    rd_ptr_nxt = rd_ptr;
    if (wr_ok) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end
    if (rd_ok) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end
  end

  // Fill level after this edge, modulo wrap
  assign level_nxt = wr_ptr_nxt - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      empty    <= 1'b1;
      full     <= 1'b0;
      afull    <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      wr_ptr   <= wr_ptr_nxt;
      rd_ptr   <= rd_ptr_nxt;
      empty    <= (level_nxt == '0);
      full     <= (level_nxt == FIFO_DEPTH);
      afull    <= (int'(level_nxt) + AFULL_MARGIN > FIFO_DEPTH);
      rd_valid <= rd_ok;
    end
  end

  // ----------------------------------------------------------
  // Storage and registered read port
  // ----------------------------------------------------------
  always_ff @(posedge rd_clk) begin
    if (wr_ok) begin
      mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
    end
  end

  // Data lands together with rd_valid
  always_ff @(posedge rd_clk) begin
    if (rd_ok) begin
      rd_beat <= mem[rd_ptr[ADDR_W-1:0]];
    end
  end

endmodule

//--- src/payload_incr.sv
`timescale 1ns/1ps

module payload_incr import pkt_pkg::*; (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  // Ingress FIFO read side
  input  logic  in_empty,
  output logic  in_rd_en,
  input  logic  in_valid,
  input  beat_t in_beat,
  // Egress FIFO write side
  input  logic  out_afull,
  output logic  out_wr_en,
  output beat_t out_beat
);

  data_t data_inc;

  // Two beats may already be in flight, the afull margin covers them
  assign in_rd_en = !in_empty && !out_afull;

  // Wraps to zero on an all-ones word
  assign data_inc = in_beat.data + 1'b1;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      out_wr_en <= 1'b0;
    end else begin
      out_wr_en <= in_valid;
    end
  end

  // Framing passes through untouched
  always_ff @(posedge rd_clk) begin
    if (in_valid) begin
      out_beat.sop   <= in_beat.sop;
      out_beat.eop   <= in_beat.eop;
      out_beat.empty <= in_beat.empty;
      out_beat.data  <= data_inc;
    end
  end

endmodule

//--- src/pkt_loopback_top.sv
`timescale 1ns/1ps

module pkt_loopback_top import pkt_pkg::*; #(
  parameter int FIFO_DEPTH = 8,
  parameter int MAX_BEATS  = 16
) (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  // Receive port
  input  logic  rx_valid,
  output logic  rx_ready,
  input  beat_t rx_beat,
  // Transmit port
  input  logic  tx_enable,
  input  logic  tx_ready,
  output logic  tx_valid,
  output beat_t tx_beat
);

  // Ingress FIFO to payload stage
  logic  ing_full;
  logic  ing_rd_en;
  logic  ing_valid;
  logic  ing_empty;
  beat_t ing_beat;

  // Payload stage to egress FIFO
  logic  egr_wr_en;
  logic  egr_afull;
  beat_t egr_wr_beat;

  // Egress FIFO to transmitter
  logic  egr_rd_en;
  logic  egr_valid;
  logic  egr_empty;
  beat_t egr_beat;

  // Source stalls on a full ingress FIFO
  assign rx_ready = !ing_full;

  // ----------------------------------------------------------
  // Ingress FIFO
  // ----------------------------------------------------------
  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ingress_fifo (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (rx_valid),
    .wr_beat  (rx_beat),
    .full     (ing_full),
    .afull    (),
    .rd_en    (ing_rd_en),
    .rd_valid (ing_valid),
    .rd_beat  (ing_beat),
    .empty    (ing_empty)
  );

  payload_incr u_payload_incr (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .in_empty  (ing_empty),
    .in_rd_en  (ing_rd_en),
    .in_valid  (ing_valid),
    .in_beat   (ing_beat),
    .out_afull (egr_afull),
    .out_wr_en (egr_wr_en),
    .out_beat  (egr_wr_beat)
  );

  // ----------------------------------------------------------
  // Egress FIFO and store-and-forward transmitter
  // ----------------------------------------------------------
  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_egress_fifo (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (egr_wr_en),
    .wr_beat  (egr_wr_beat),
    .full     (),
    .afull    (egr_afull),
    .rd_en    (egr_rd_en),
    .rd_valid (egr_valid),
    .rd_beat  (egr_beat),
    .empty    (egr_empty)
  );

  tx_packet_buffer #(
    .MAX_BEATS (MAX_BEATS)
  ) u_tx_buffer (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .tx_enable  (tx_enable),
    .fifo_empty (egr_empty),
    .fifo_rd_en (egr_rd_en),
    .fifo_valid (egr_valid),
    .fifo_beat  (egr_beat),
    .tx_ready   (tx_ready),
    .tx_valid   (tx_valid),
    .tx_beat    (tx_beat)
  );

endmodule

//--- src/pkt_pkg.sv
package pkt_pkg;

  // ----------------------------------------------------------
  // Beat geometry
  // ----------------------------------------------------------
  localparam int DATA_W  = 64;
  // Byte count of an 8-byte word needs 3 bits
  localparam int EMPTY_W = 3;

  // Payload word of one beat
  typedef logic [DATA_W-1:0]  data_t;
  // Unused bytes in the last beat of a packet
  typedef logic [EMPTY_W-1:0] empty_t;

  // ----------------------------------------------------------
  // Streaming beat, 69 bits with sop in the top bit
  // ----------------------------------------------------------
  typedef struct packed {
    logic   sop;
    logic   eop;
    empty_t empty;
    data_t  data;
  } beat_t;

  // ----------------------------------------------------------
  // Transmit FSM states
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    // Pull beats from the egress FIFO until eop
    TX_LOAD = 2'd1,
    TX_SEND = 2'd2,
    TX_DONE = 2'd3
  } tx_state_t;

endpackage

//--- src/tx_packet_buffer.sv
`timescale 1ns/1ps

module tx_packet_buffer import pkt_pkg::*; #(
  parameter int MAX_BEATS = 16
) (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  tx_enable,
  // Egress FIFO read side
  input  logic  fifo_empty,
  output logic  fifo_rd_en,
  input  logic  fifo_valid,
  input  beat_t fifo_beat,
  // Transmit port
  input  logic  tx_ready,
  output logic  tx_valid,
  output beat_t tx_beat
);

  localparam int IDX_W = $clog2(MAX_BEATS);
  // Load pointer must be able to hold MAX_BEATS itself
  localparam int PTR_W = $clog2(MAX_BEATS + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  tx_state_t state;
  tx_state_t state_nxt;

  beat_t pkt_mem [MAX_BEATS];

  ptr_t  load_ptr;
  ptr_t  last_ptr;
  ptr_t  send_ptr;
  logic  overflow;
  logic  send_last;
  beat_t send_beat;

  // Packet too long for the buffer, further beats are discarded
  assign overflow  = (load_ptr == ptr_t'(MAX_BEATS));
  assign send_last = (send_ptr == last_ptr);

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      TX_IDLE: begin
        if (tx_enable && !fifo_empty) begin
          state_nxt = TX_LOAD;
        end
      end
      TX_LOAD: begin
        if (fifo_valid && fifo_beat.eop) begin
          state_nxt = overflow ? TX_IDLE : TX_SEND;
        end
      end
      TX_SEND: begin
        if (tx_ready && send_last) begin
          state_nxt = TX_DONE;
        end
      end
      default: begin
        state_nxt = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state    <= TX_IDLE;
      load_ptr <= '0;
      last_ptr <= '0;
      send_ptr <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        TX_IDLE: begin
          load_ptr <= '0;
          send_ptr <= '0;
        end
        TX_LOAD: begin
          if (fifo_valid) begin
            if (!overflow) begin
              load_ptr <= load_ptr + 1'b1;
            end
            if (fifo_beat.eop) begin
              last_ptr <= load_ptr;
            end
          end
        end
        TX_SEND: begin
          if (tx_ready) begin
            send_ptr <= send_ptr + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // One read outstanding at a time, so nothing past eop is fetched
  assign fifo_rd_en = (state == TX_LOAD) && !fifo_empty && !fifo_valid;

  always_ff @(posedge rd_clk) begin
    if (state == TX_LOAD && fifo_valid && !overflow) begin
      pkt_mem[load_ptr[IDX_W-1:0]] <= fifo_beat;
    end
  end

  // ----------------------------------------------------------
  // Transmit port
  // ----------------------------------------------------------
  assign send_beat = pkt_mem[send_ptr[IDX_W-1:0]];
  assign tx_valid  = (state == TX_SEND);

  // Framing rebuilt from position in the packet
  always_comb begin
    tx_beat.sop   = tx_valid && (send_ptr == '0);
    tx_beat.eop   = tx_valid && send_last;
    tx_beat.empty = (tx_valid && send_last) ? send_beat.empty : '0;
    tx_beat.data  = tx_valid ? send_beat.data : '0;
  end

endmodule

//--- verification/pkt_checker.sv
`timescale 1ns/1ps

module pkt_checker import pkt_pkg::*; #(
  parameter int MAX_ENTRIES = 32
) (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rx_ready,
  input  logic  tx_enable,
  input  logic  tx_ready,
  input  logic  tx_valid,
  input  beat_t tx_beat,
  // Expected output beats in transmit order
  input  beat_t exp_tbl [MAX_ENTRIES],
  input  int    exp_len,
  input  logic  end_of_test,
  output int    beats_seen,
  output int    err_count,
  output logic  report_done
);

  int    seen        = 0;
  int    errors      = 0;
  int    pkt_count   = 0;
  int    pkt_beats   = 0;
  int    pkt_errs    = 0;
  int    pass_count  = 0;
  int    fail_count  = 0;
  logic  enable_seen = 1'b0;
  logic  stalled     = 1'b0;
  logic  reported    = 1'b0;
  beat_t held_beat;

  assign beats_seen  = seen;
  assign err_count   = errors;
  assign report_done = reported;

  task automatic compare_field(input string name, input data_t exp_val, input data_t act_val);
    if (exp_val !== act_val) begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
      errors++;
      pkt_errs++;
    end
  endtask

  task automatic compare_beat(input string tag, input beat_t exp_beat, input beat_t act_beat);
    compare_field({tag, ".sop"}, data_t'(exp_beat.sop), data_t'(act_beat.sop));
    compare_field({tag, ".eop"}, data_t'(exp_beat.eop), data_t'(act_beat.eop));
    compare_field({tag, ".empty"}, data_t'(exp_beat.empty), data_t'(act_beat.empty));
    compare_field({tag, ".data"}, exp_beat.data, act_beat.data);
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    errors++;
    pkt_errs++;
  endtask

  // ----------------------------------------------------------
  // One transferred beat
  // ----------------------------------------------------------
  task automatic check_beat();
    if (seen >= exp_len) begin
      report_problem($sformatf("extra beat on the transmit port, data %h", tx_beat.data));
    end else begin
      compare_beat("tx_beat", exp_tbl[seen], tx_beat);
    end
    seen++;
    pkt_beats++;
    if (tx_beat.eop) begin
      if (pkt_errs == 0) begin
        pass_count++;
        $display("Packet %0d: %0d beats, passed", pkt_count, pkt_beats);
      end else begin
        fail_count++;
        $display("Packet %0d: %0d beats, failed with %0d errors", pkt_count, pkt_beats,
                 pkt_errs);
      end
      pkt_count++;
      pkt_beats = 0;
      pkt_errs  = 0;
    end
  endtask

  // Ports sampled mid-cycle between rising edges
  always @(negedge rd_clk) begin
    if (!rd_rst_n) begin
      if (tx_valid !== 1'b0) begin
        report_problem("tx_valid is not low during reset");
      end
      compare_beat("reset tx_beat", '0, tx_beat);
      if (rx_ready !== 1'b1) begin
        report_problem("rx_ready is not high during reset");
      end
      stalled = 1'b0;
    end else begin
      if (tx_enable) begin
        enable_seen = 1'b1;
      end
      if (tx_valid && !enable_seen) begin
        report_problem("tx_valid rose before tx_enable was ever raised");
      end
      // Stalled beat must be held
      if (stalled) begin
        if (!tx_valid) begin
          report_problem("tx_valid dropped while tx_ready was low");
        end else begin
          compare_beat("stalled tx_beat", held_beat, tx_beat);
        end
      end
      // No payload between beats
      if (!tx_valid) begin
        compare_field("idle tx_beat.data", '0, tx_beat.data);
      end
      if (tx_valid && tx_ready) begin
        check_beat();
      end
      stalled   = tx_valid && !tx_ready;
      held_beat = tx_beat;
    end

    if (end_of_test && !reported) begin
      if (seen < exp_len) begin
        report_problem($sformatf("missing packets, only %0d of %0d beats arrived",
                                 seen, exp_len));
      end
      $display("Packets passed: %0d, failed: %0d, total errors: %0d",
               pass_count, fail_count, errors);
      reported = 1'b1;
    end
  end

endmodule

//--- verification/tb_pkt_loopback.sv
`timescale 1ns/1ps

module tb_pkt_loopback import pkt_pkg::*; ();

  localparam int          TBL_LEN        = 22;
  localparam int          HALF_PERIOD    = 5;
  localparam int          TIMEOUT_CYCLES = TBL_LEN * 200;
  localparam logic [31:0] LFSR_SEED      = 32'd76178;

  logic  rd_clk = 1'b0;
  logic  rd_rst_n;
  logic  rx_valid;
  logic  rx_ready;
  beat_t rx_beat;
  logic  tx_enable;
  logic  tx_ready;
  logic  tx_valid;
  beat_t tx_beat;

  // Input beats and the beats expected on the transmit port
  beat_t in_tbl  [TBL_LEN];
  beat_t exp_tbl [TBL_LEN];
  int    rows = 0;

  logic [31:0] lfsr_state = LFSR_SEED;
  logic        run_done   = 1'b0;
  logic        timed_out  = 1'b0;
  logic        end_of_test;
  logic        report_done;
  int          beats_seen;
  int          err_count;

  assign end_of_test = run_done || timed_out;

  always #HALF_PERIOD rd_clk = ~rd_clk;

  pkt_loopback_top #(
    .FIFO_DEPTH (8),
    .MAX_BEATS  (16)
  ) i_dut (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .rx_beat   (rx_beat),
    .tx_enable (tx_enable),
    .tx_ready  (tx_ready),
    .tx_valid  (tx_valid),
    .tx_beat   (tx_beat)
  );

  pkt_checker #(
    .MAX_ENTRIES (TBL_LEN)
  ) u_checker (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rx_ready    (rx_ready),
    .tx_enable   (tx_enable),
    .tx_ready    (tx_ready),
    .tx_valid    (tx_valid),
    .tx_beat     (tx_beat),
    .exp_tbl     (exp_tbl),
    .exp_len     (rows),
    .end_of_test (end_of_test),
    .beats_seen  (beats_seen),
    .err_count   (err_count),
    .report_done (report_done)
  );

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic add_beat(input logic sop, input logic eop, input empty_t empty,
                          input data_t data);
    in_tbl[rows].sop    = sop;
    in_tbl[rows].eop    = eop;
    in_tbl[rows].empty  = empty;
    in_tbl[rows].data   = data;
    // Data plus one, empty kept only on the last beat
    exp_tbl[rows].sop   = sop;
    exp_tbl[rows].eop   = eop;
    exp_tbl[rows].empty = eop ? empty : '0;
    exp_tbl[rows].data  = data + data_t'(1);
    rows++;
  endtask

  // Middle beats carry a nonzero empty that must be cleared
  task automatic add_packet(input int len, input logic [7:0] tag, input empty_t last_empty);
    for (int b = 0; b < len; b++) begin
      add_beat(b == 0, b == len - 1, (b == len - 1) ? last_empty : empty_t'(b),
               {tag, 8'(b), 48'h5a5a_0f0f_1234});
    end
  endtask

  task automatic build_table();
    add_beat(1'b1, 1'b1, 3'd5, 64'h0123_4567_89ab_cdef);
    add_beat(1'b1, 1'b0, 3'd0, 64'hffff_ffff_ffff_ffff);
    add_beat(1'b0, 1'b0, 3'd6, 64'h0000_0000_0000_00ff);
    add_beat(1'b0, 1'b1, 3'd2, 64'h7fff_ffff_ffff_ffff);
    add_packet(4, 8'h21, 3'd7);
    add_packet(8, 8'h33, 3'd1);
    add_packet(6, 8'h4c, 3'd0);
  endtask

  // Called right after a rising edge
  task automatic send_table();
    bit accepted;
    for (int i = 0; i < rows; i++) begin
      rx_valid <= 1'b1;
      rx_beat  <= in_tbl[i];
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge rd_clk);
        accepted = rx_ready;
        @(posedge rd_clk);
      end
    end
    rx_valid <= 1'b0;
    rx_beat  <= '0;
  endtask

  // Line comes up only once the source has been stalled
  task automatic enable_after_stall();
    do begin
      @(negedge rd_clk);
    end while (rx_ready);
    repeat (10) @(posedge rd_clk);
    tx_enable <= 1'b1;
  endtask

  function automatic logic [31:0] step_lfsr(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Random sink back-pressure
  always @(posedge rd_clk) begin
    lfsr_state = step_lfsr(lfsr_state);
    tx_ready <= lfsr_state[0];
  end

  initial begin
    rd_rst_n  = 1'b0;
    rx_valid  = 1'b0;
    rx_beat   = '0;
    tx_enable = 1'b0;
    tx_ready  = 1'b0;
    build_table();
    repeat (8) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(posedge rd_clk);
    fork
      send_table();
      enable_after_stall();
    join
    wait (beats_seen >= rows);
    // Room for any extra beat to show up
    repeat (30) @(posedge rd_clk);
    run_done <= 1'b1;
    wait (report_done);
    if (err_count == 0 && beats_seen == rows) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge rd_clk);
    $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
    timed_out <= 1'b1;
    wait (report_done);
    $display("Finished with errors");
    $finish;
  end

endmodule
